/* serial_core_pkg.sv */
`default_nettype none

package serial_core_pkg;

    // datapath geometry, one byte part handled per cycle
    localparam int XLEN      = 64;
    localparam int BYTE_W    = 8;
    localparam int NUM_PARTS = XLEN / BYTE_W;
    localparam int PART_W    = 3;

    // register file shape
    localparam int REG_COUNT = 8;
    localparam int REG_IDX_W = 3;

    // instruction word fields
    localparam int INSTR_W   = 32;
    localparam int OP_W      = 4;
    localparam int IMM_W     = 12;

    // opcode values, anything above OP_BLT is illegal
    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,
        OP_XORI = 4'd6,
        OP_BEQ  = 4'd7,
        OP_BNE  = 4'd8,
        OP_BLTU = 4'd9,
        OP_BLT  = 4'd10
    } alu_op_e;

    // register form, two source registers
    typedef struct packed {
        logic [OP_W-1:0]                      opcode;
        logic [REG_IDX_W-1:0]                 rd;
        logic [REG_IDX_W-1:0]                 rs1;
        logic [REG_IDX_W-1:0]                 rs2;
        logic [INSTR_W-OP_W-3*REG_IDX_W-1:0]  unused;
    } r_form_t;

    // immediate form, imm sits where rs2 and the spare bits are
    typedef struct packed {
        logic [OP_W-1:0]                           opcode;
        logic [REG_IDX_W-1:0]                      rd;
        logic [REG_IDX_W-1:0]                      rs1;
        logic [IMM_W-1:0]                          imm;
        logic [INSTR_W-OP_W-2*REG_IDX_W-IMM_W-1:0] unused;
    } i_form_t;

    // same 32-bit word, opcode picks which view is meaningful
    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_word_u;

    // decoded instruction held for the whole 8-part run
    typedef struct packed {
        alu_op_e              op;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [IMM_W-1:0]     imm;
        // fill value for the bytes above the imm field
        logic                 imm_sign;
        logic                 uses_imm;
        logic                 writes_rd;
        logic                 is_compare;
        logic                 illegal;
    } decoded_instr_t;

    // one result byte per cycle from execute
    typedef struct packed {
        logic                 valid;
        logic [PART_W-1:0]    part;
        logic [REG_IDX_W-1:0] rd;
        logic                 write;
        logic [BYTE_W-1:0]    value;
        logic                 last;
        logic                 flag;
        logic                 illegal;
    } byte_result_t;

endpackage

`default_nettype wire

/* instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    import serial_core_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           instr_valid,
    input  instr_word_u    instr,
    input  logic           exec_last,
    output logic           start,
    output decoded_instr_t decoded,
    output logic           busy
);

    logic           accept;
    decoded_instr_t next_decoded;

    always_comb begin
        // one instruction in flight, so valid while busy is simply dropped
        accept = instr_valid && !busy;

        next_decoded = '0;
        next_decoded.op  = alu_op_e'(instr.r.opcode);
        // rd and rs1 share positions in both forms
        next_decoded.rd  = instr.r.rd;
        next_decoded.rs1 = instr.r.rs1;

        case (alu_op_e'(instr.r.opcode))
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                next_decoded.writes_rd = 1'b1;
            end
            OP_ADDI, OP_XORI: begin
                next_decoded.uses_imm  = 1'b1;
                next_decoded.writes_rd = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BLTU, OP_BLT: begin
                // compares only raise a flag, rd untouched
                next_decoded.is_compare = 1'b1;
            end
            default: begin
                next_decoded.illegal = 1'b1;
            end
        endcase

        // pick the view of the word that this opcode uses
        if (next_decoded.uses_imm) begin
            next_decoded.imm      = instr.i.imm;
            next_decoded.imm_sign = instr.i.imm[IMM_W-1];
        end else begin
            next_decoded.rs2 = instr.r.rs2;
        end
    end

    // start pulses in the cycle of part 0, busy drops when part 7 retires
    always_ff @(posedge clock) begin
        if (reset) begin
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (exec_last) begin
                busy <= 1'b0;
            end
        end
    end

    // held stable for the run, only loaded on acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            decoded <= next_decoded;
        end
    end

endmodule

`default_nettype wire

/* byte_serial_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_serial_execute
    import serial_core_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  decoded_instr_t       decoded,
    input  logic [BYTE_W-1:0]    rs1_byte,
    input  logic [BYTE_W-1:0]    rs2_byte,
    output logic [PART_W-1:0]    rd_part_index,
    output logic [REG_IDX_W-1:0] rs1_sel,
    output logic [REG_IDX_W-1:0] rs2_sel,
    output byte_result_t         byte_out
);

    logic              active;
    logic              running;
    logic [PART_W-1:0] part;
    logic              carry;
    logic              cmp_state;
    logic              first_part;
    logic              last_part;
    logic [BYTE_W-1:0] imm_byte;
    logic [BYTE_W-1:0] b_byte;
    logic              subtract;
    logic              carry_in;
    logic [BYTE_W:0]   sum;
    logic [BYTE_W-1:0] alu_byte;
    logic              byte_eq;
    logic              byte_ltu;
    logic              byte_lts;
    logic              cmp_next;

    always_comb begin
        // part 0 runs in the start cycle, parts 1..7 while active
        running    = start || active;
        first_part = (part == '0);
        last_part  = (part == PART_W'(NUM_PARTS - 1));

        // imm spans byte 0 and the low nibble of byte 1, then sign fill
        if (first_part) begin
            imm_byte = decoded.imm[BYTE_W-1:0];
        end else if (part == PART_W'(1)) begin
            imm_byte = {{(2*BYTE_W-IMM_W){decoded.imm_sign}}, decoded.imm[IMM_W-1:BYTE_W]};
        end else begin
            imm_byte = {BYTE_W{decoded.imm_sign}};
        end
        b_byte = decoded.uses_imm ? imm_byte : rs2_byte;

        // subtract is a + ~b + 1, the +1 enters as carry into part 0
        subtract = (decoded.op == OP_SUB) || decoded.is_compare;
        carry_in = first_part ? subtract : carry;
        sum = {1'b0, rs1_byte} + {1'b0, (subtract ? ~b_byte : b_byte)}
            + (BYTE_W+1)'(carry_in);

        case (decoded.op)
            OP_AND:          alu_byte = rs1_byte & b_byte;
            OP_OR:           alu_byte = rs1_byte | b_byte;
            OP_XOR, OP_XORI: alu_byte = rs1_byte ^ b_byte;
            // add, sub and the compares all return the sum
            default:         alu_byte = sum[BYTE_W-1:0];
        endcase

        // compare chain, low bytes decide unless a higher byte differs
        byte_eq  = (rs1_byte == b_byte);
        byte_ltu = (rs1_byte < b_byte);
        byte_lts = ($signed(rs1_byte) < $signed(b_byte));
        case (decoded.op)
            OP_BEQ:  cmp_next = byte_eq && (first_part || cmp_state);
            OP_BNE:  cmp_next = !byte_eq || (!first_part && cmp_state);
            OP_BLTU: cmp_next = byte_ltu || (byte_eq && !first_part && cmp_state);
            // top byte carries the sign for BLT
            OP_BLT:  cmp_next = (last_part ? byte_lts : byte_ltu)
                              || (byte_eq && !first_part && cmp_state);
            default: cmp_next = 1'b0;
        endcase

        rd_part_index = part;
        rs1_sel       = decoded.rs1;
        rs2_sel       = decoded.rs2;

        byte_out.valid   = running;
        byte_out.part    = part;
        byte_out.rd      = decoded.rd;
        byte_out.write   = decoded.writes_rd && !decoded.illegal;
        byte_out.value   = decoded.illegal ? '0 : alu_byte;
        byte_out.last    = running && last_part;
        // flag only means something on the final part
        byte_out.flag    = last_part && decoded.is_compare && cmp_next;
        byte_out.illegal = decoded.illegal;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            active    <= 1'b0;
            part      <= '0;
            carry     <= 1'b0;
            cmp_state <= 1'b0;
        end else if (running) begin
            active    <= !last_part;
            // wraps back to 0 after part 7
            part      <= part + PART_W'(1);
            carry     <= sum[BYTE_W];
            cmp_state <= cmp_next;
        end
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import serial_core_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [PART_W-1:0]    rd_part_index,
    input  logic [REG_IDX_W-1:0] rs1_sel,
    input  logic [REG_IDX_W-1:0] rs2_sel,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_reg,
    input  logic [PART_W-1:0]    wr_part,
    input  logic [BYTE_W-1:0]    wr_byte,
    output logic [BYTE_W-1:0]    rs1_byte,
    output logic [BYTE_W-1:0]    rs2_byte
);

    // one byte lane per part in each register
    logic [REG_COUNT-1:0][NUM_PARTS-1:0][BYTE_W-1:0] regs;

    // both ports read the same part, x0 is hardwired to zero
    always_comb begin
        if (rs1_sel == '0) begin
            rs1_byte = '0;
        end else begin
            rs1_byte = regs[rs1_sel][rd_part_index];
        end

        if (rs2_sel == '0) begin
            rs2_byte = '0;
        end else begin
            rs2_byte = regs[rs2_sel][rd_part_index];
        end
    end

    // single byte write per edge
    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '0;
        end else if (wr_en && (wr_reg != '0)) begin
            regs[wr_reg][wr_part] <= wr_byte;
        end
    end

endmodule

`default_nettype wire

/* result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage
    import serial_core_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  byte_result_t         byte_out,
    output logic                 wr_en,
    output logic [REG_IDX_W-1:0] wr_reg,
    output logic [PART_W-1:0]    wr_part,
    output logic [BYTE_W-1:0]    wr_byte,
    output logic                 done,
    output logic [XLEN-1:0]      result_value,
    output logic                 flag,
    output logic                 illegal
);

    // parts 0..6 collected here, part 7 joins on the final edge
    logic [XLEN-BYTE_W-1:0] gather;

    // byte k lands in the register file at the edge that ends its cycle
    always_comb begin
        wr_en   = byte_out.valid && byte_out.write;
        wr_reg  = byte_out.rd;
        wr_part = byte_out.part;
        wr_byte = byte_out.value;
    end

    // lowest byte first, so shift in from the top
    always_ff @(posedge clock) begin
        if (byte_out.valid) begin
            gather <= {byte_out.value, gather[XLEN-BYTE_W-1:BYTE_W]};
            if (byte_out.last) begin
                result_value <= {byte_out.value, gather};
            end
        end
    end

    // done is a single pulse, flag and illegal hold until the next run ends
    always_ff @(posedge clock) begin
        if (reset) begin
            done    <= 1'b0;
            flag    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            done <= byte_out.valid && byte_out.last;
            if (byte_out.valid && byte_out.last) begin
                flag    <= byte_out.flag;
                illegal <= byte_out.illegal;
            end
        end
    end

endmodule

`default_nettype wire

/* serial_core.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_core
    import serial_core_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            instr_valid,
    input  instr_word_u     instr,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] result_value,
    output logic            flag,
    output logic            illegal
);

    decoded_instr_t       decoded;
    logic                 start;
    logic [PART_W-1:0]    rd_part_index;
    logic [REG_IDX_W-1:0] rs1_sel;
    logic [REG_IDX_W-1:0] rs2_sel;
    logic [BYTE_W-1:0]    rs1_byte;
    logic [BYTE_W-1:0]    rs2_byte;
    byte_result_t         byte_out;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_reg;
    logic [PART_W-1:0]    wr_part;
    logic [BYTE_W-1:0]    wr_byte;

    // acceptance and busy
    instr_decode u_instr_decode (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .exec_last   (byte_out.last),
        .start       (start),
        .decoded     (decoded),
        .busy        (busy)
    );

    // eight parts, one per cycle
    byte_serial_execute u_byte_serial_execute (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .decoded       (decoded),
        .rs1_byte      (rs1_byte),
        .rs2_byte      (rs2_byte),
        .rd_part_index (rd_part_index),
        .rs1_sel       (rs1_sel),
        .rs2_sel       (rs2_sel),
        .byte_out      (byte_out)
    );

    register_file u_register_file (
        .clock         (clock),
        .reset         (reset),
        .rd_part_index (rd_part_index),
        .rs1_sel       (rs1_sel),
        .rs2_sel       (rs2_sel),
        .wr_en         (wr_en),
        .wr_reg        (wr_reg),
        .wr_part       (wr_part),
        .wr_byte       (wr_byte),
        .rs1_byte      (rs1_byte),
        .rs2_byte      (rs2_byte)
    );

    // write-back and completion
    result_stage u_result_stage (
        .clock        (clock),
        .reset        (reset),
        .byte_out     (byte_out),
        .wr_en        (wr_en),
        .wr_reg       (wr_reg),
        .wr_part      (wr_part),
        .wr_byte      (wr_byte),
        .done         (done),
        .result_value (result_value),
        .flag         (flag),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

/* serial_core_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_core_sva
    import serial_core_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic instr_valid,
    input logic busy,
    input logic done
);

    logic accept;

    // same acceptance condition as the decoder
    assign accept = instr_valid && !busy;

    // done is a one-cycle pulse
    done_single_cycle: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // done shows up in the cycle after the eighth edge
    done_latency: assert property (@(posedge clock) disable iff (reset)
        accept |-> ##(NUM_PARTS + 1) done)
        else $error("done did not follow acceptance after eight edges");

    // next instruction may enter in the done cycle
    busy_low_at_done: assert property (@(posedge clock) disable iff (reset)
        done |-> !busy)
        else $error("busy was high together with done");

endmodule

bind serial_core serial_core_sva u_serial_core_sva (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .busy        (busy),
    .done        (done)
);

`default_nettype wire

/* tb_serial_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_serial_core
    import serial_core_pkg::*;
();

    // ADD x1, x0, x0, would clobber x1 if it slipped in while busy
    localparam logic [31:0] JUNK_WORD = 32'h0200_0000;

    logic            clock;
    logic            reset;
    logic            instr_valid;
    instr_word_u     instr;
    logic            busy;
    logic            done;
    logic [XLEN-1:0] result_value;
    logic            flag;
    logic            illegal;

    logic [31:0]     vec_word [$];
    logic [XLEN-1:0] vec_result [$];
    logic            vec_flag [$];
    logic            vec_illegal [$];

    int          cycle_count;
    int          cycle_limit = 0;
    int          error_count;
    logic [31:0] lcg_state;

    serial_core u_serial_core (
        .clock        (clock),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .busy         (busy),
        .done         (done),
        .result_value (result_value),
        .flag         (flag),
        .illegal      (illegal)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // limit only armed once the vector count is known
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count = cycle_count + 1;
            if (cycle_limit > 0 && cycle_count > cycle_limit) begin
                $display("timeout: run did not finish within %0d cycles", cycle_limit);
                $display("** FAIL **");
                $fatal(1, "simulation timed out");
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic read_vectors();
        int              fd;
        int              count;
        string           line;
        logic [31:0]     word;
        logic [XLEN-1:0] result;
        logic [31:0]     flag_bit;
        logic [31:0]     illegal_bit;
        fd = $fopen("serial_core_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open serial_core_vectors.txt");
            $display("** FAIL **");
            $fatal(1, "vector file missing");
        end
        while ($fgets(line, fd) != 0) begin
            // skip blank lines and lines starting with '#'
            if (line.len() > 1 && line.getc(0) != 8'h23) begin
                count = $sscanf(line, "%h %h %h %h", word, result, flag_bit, illegal_bit);
                if (count != 4) begin
                    $display("malformed vector line: %s", line);
                    $display("** FAIL **");
                    $fatal(1, "bad vector file");
                end
                vec_word.push_back(word);
                vec_result.push_back(result);
                vec_flag.push_back(flag_bit[0]);
                vec_illegal.push_back(illegal_bit[0]);
            end
        end
        $fclose(fd);
    endtask

    // junk first while busy, then the next word early when the gap is zero
    task automatic drive_busy_window(input int edges, input int distract, input int gap,
                                     input int next_index);
        if (edges < distract) begin
            instr_valid <= 1'b1;
            instr       <= JUNK_WORD;
        end else if (gap == 0 && next_index < vec_word.size()) begin
            instr_valid <= 1'b1;
            instr       <= vec_word[next_index];
        end else begin
            instr_valid <= 1'b0;
        end
    endtask

    initial begin : stimulus
        int   gap;
        int   distract;
        int   edges;
        logic preloaded;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        error_count = 0;
        lcg_state   = 32'h6415_6daf;
        read_vectors();
        cycle_limit = vec_word.size() * 14 + 50;

        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        preloaded = 1'b0;

        for (int i = 0; i < vec_word.size(); i++) begin
            if (!preloaded) begin
                instr_valid <= 1'b1;
                instr       <= vec_word[i];
                @(negedge clock);
            end
            // valid high with busy low mid-cycle means acceptance at the next edge
            while (busy) @(negedge clock);
            @(posedge clock);

            lcg_state = lcg_next(lcg_state);
            gap       = int'(lcg_state[17:16]);
            distract  = int'(lcg_state[21:20]);

            edges = 0;
            drive_busy_window(edges, distract, gap, i + 1);
            @(negedge clock);
            while (!done) begin
                @(posedge clock);
                edges = edges + 1;
                drive_busy_window(edges, distract, gap, i + 1);
                @(negedge clock);
            end

            // outputs sampled mid-cycle in the done cycle
            check_value("latency", 64'(NUM_PARTS), 64'(edges));
            check_value("result_value", vec_result[i], result_value);
            check_value("flag", 64'(vec_flag[i]), 64'(flag));
            check_value("illegal", 64'(vec_illegal[i]), 64'(illegal));
            check_value("busy", 64'(0), 64'(busy));

            preloaded = (gap == 0) && (i + 1 < vec_word.size());
            if (!preloaded) begin
                repeat (gap) @(posedge clock);
            end
        end

        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* serial_core_vectors.txt */
# instr_word  expected_result   flag  illegal   (all hex)
# one instruction per line, run in order against a register file cleared by reset
523FFC00 FFFFFFFFFFFFFFFF 0 0
54400000 FFFFFFFFFFFFFFFF 0 0
561FFC00 00000000000007FF 0 0
58200000 FFFFFFFFFFFFF800 0 0
5C000400 0000000000000001 0 0
# add and sub with carries across byte boundaries
0AD80000 0000000000000FFE 0 0
0A700000 0000000000000000 0 0
0B200000 FFFFFFFFFFFFF000 0 0
1EE00000 0000000000000FFF 0 0
1E300000 FFFFFFFFFFFFFFFF 0 0
# logic ops over all 64 bits
2B600000 FFFFFFFFFFFFF000 0 0
3AE00000 FFFFFFFFFFFFFFFF 0 0
4B300000 FFFFFFFFFFFFF801 0 0
6B555400 FFFFFFFFFFFFFD54 0 0
6A7FFC00 0000000000000000 0 0
# compares, result is rs1 minus rs2
70500000 0000000000000000 1 0
80E00000 0000000000000FFF 1 0
91180000 FFFFFFFFFFFFF001 0 0
AF180000 FFFFFFFFFFFFF001 1 0
90E00000 0000000000000FFF 1 0
A0E00000 0000000000000FFF 0 0
A1080000 FFFFFFFFFFFFF801 1 0
# x7 survives the compare with rd 7, x0 ignores writes
5BC00000 FFFFFFFFFFFFFFFF 0 0
50400000 FFFFFFFFFFFFFFFF 0 0
5A000000 0000000000000000 0 0
# illegal opcode then x7 read back again
BE480000 0000000000000000 0 1
5BC00000 FFFFFFFFFFFFFFFF 0 0

/* sim.f */
serial_core_pkg.sv
instr_decode.sv
byte_serial_execute.sv
register_file.sv
result_stage.sv
serial_core.sv
serial_core_sva.sv
tb_serial_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the serial core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_serial_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_serial_core 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
else
    exit 1
fi
